// ==== verilog/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    // ========================================
    // Line and burst geometry
    // ========================================
    localparam int line_bytes     = 32;           // One cache line
    localparam int beats_per_line = 4;            // Fixed burst length on the memory bus
    localparam int beat_width     = 64;           // Bits carried by one burst beat

    // ========================================
    // Vector types
    // ========================================
    typedef logic [31:0] rv32i_word;                              // Byte address or data word
    typedef logic [8*line_bytes-1:0] cache_line_t;                // Whole line, 256 bits
    typedef logic [beat_width-1:0] burst_beat_t;                  // One beat on the burst bus
    typedef logic [$clog2(beats_per_line)-1:0] beat_count_t;      // Beat index within a burst

endpackage : rv32i_types

`default_nettype wire

// ==== verilog/line_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_arbiter
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,

    // Line port toward the burst adaptor
    input  cache_line_t mem_rdata,
    input  logic        mem_resp,
    output rv32i_word   mem_addr,
    output logic        mem_read,
    output logic        mem_write,
    output cache_line_t mem_wdata,

    // Instruction cache
    input  logic        inst_read,
    input  rv32i_word   inst_addr,
    output logic        inst_resp,
    output cache_line_t inst_rdata,

    // Data cache
    input  logic        data_read,
    input  logic        data_write,
    input  rv32i_word   data_addr,
    input  cache_line_t data_wdata,
    output logic        data_resp,
    output cache_line_t data_rdata
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_inst,
        arb_data
    } arb_state_t;

    arb_state_t state;
    arb_state_t next_state;

    logic data_pending;

    assign data_pending = data_read || data_write;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        next_state = state;
        if (flush) begin
            next_state = arb_idle;                // Drop ownership at once
        end else begin
            case (state)
                arb_idle: begin
                    if (data_pending) begin
                        next_state = arb_data;    // Data side wins a tie from idle
                    end else if (inst_read) begin
                        next_state = arb_inst;
                    end
                end
                arb_inst: begin
                    if (mem_resp) begin
                        next_state = data_pending ? arb_data : arb_idle;
                    end
                end
                arb_data: begin
                    if (mem_resp) begin
                        next_state = inst_read ? arb_inst : arb_idle;
                    end
                end
                default: begin
                    next_state = arb_idle;
                end
            endcase
        end
    end

    // ========================================
    // Port multiplexing
    // ========================================
    always_comb begin
        mem_addr   = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_wdata  = '0;
        inst_resp  = 1'b0;
        inst_rdata = '0;
        data_resp  = 1'b0;
        data_rdata = '0;
        case (state)
            arb_inst: begin
                mem_addr   = inst_addr;
                mem_read   = inst_read;           // Instruction side only ever reads
                inst_resp  = mem_resp;
                inst_rdata = mem_rdata;
            end
            arb_data: begin
                mem_addr   = data_addr;
                mem_read   = data_read;
                mem_write  = data_write;
                mem_wdata  = data_wdata;
                data_resp  = mem_resp;
                data_rdata = mem_rdata;
            end
            default: begin
                // Idle forwards nothing, so a response after a flush is lost here
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule : line_arbiter

`default_nettype wire

// ==== verilog/line_burst_adaptor.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_burst_adaptor
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,

    // Line port from the arbiter
    input  logic        mem_read,
    input  logic        mem_write,
    input  rv32i_word   mem_addr,
    input  cache_line_t mem_wdata,
    output logic        mem_resp,
    output cache_line_t mem_rdata,

    // Burst bus toward external memory
    output logic        burst_read,
    output logic        burst_write,
    output rv32i_word   burst_addr,
    output burst_beat_t burst_wdata,
    input  logic        burst_resp,
    input  burst_beat_t burst_rdata
);

    typedef enum logic [1:0] {
        adp_idle,
        adp_reading,
        adp_writing,
        adp_done
    } adp_state_t;

    adp_state_t  state;
    adp_state_t  next_state;
    beat_count_t beat_idx;
    cache_line_t line_q;

    logic in_burst;
    logic last_beat;

    assign in_burst  = (state == adp_reading) || (state == adp_writing);
    assign last_beat = in_burst && burst_resp
                       && (beat_idx == beat_count_t'(beats_per_line - 1));

    // ========================================
    // Control
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            adp_idle: begin
                if (mem_read) begin
                    next_state = adp_reading;
                end else if (mem_write) begin
                    next_state = adp_writing;
                end
            end
            adp_reading,
            adp_writing: begin
                if (last_beat) begin
                    next_state = adp_done;       // Response goes out in the done cycle
                end
            end
            adp_done: begin
                next_state = adp_idle;
            end
            default: begin
                next_state = adp_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= adp_idle;
            beat_idx <= '0;
        end else begin
            state <= next_state;
            if (!in_burst) begin
                beat_idx <= '0;
            end else if (burst_resp) begin
                beat_idx <= beat_idx + 1'b1;     // Wraps to zero after the last beat
            end
        end
    end

    // ========================================
    // Datapath
    // ========================================
    // Reads shift each beat in from the top so beat 0 ends up in the low bits.
    // Writes use the same shift to present the next beat at the bottom.
    always_ff @(posedge clk) begin
        if (state == adp_idle) begin
            burst_addr <= mem_addr & ~rv32i_word'(line_bytes - 1);
            line_q     <= mem_wdata;
        end else if (in_burst && burst_resp) begin
            line_q <= {burst_rdata, line_q[$bits(cache_line_t)-1:beat_width]};
        end
    end

    assign burst_read  = (state == adp_reading);
    assign burst_write = (state == adp_writing);
    assign burst_wdata = line_q[beat_width-1:0];

    assign mem_resp  = (state == adp_done);      // Exactly one cycle after the fourth beat
    assign mem_rdata = line_q;

endmodule : line_burst_adaptor

`default_nettype wire

// ==== verilog/memory_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_subsystem
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,

    // Instruction cache
    input  logic        inst_read,
    input  rv32i_word   inst_addr,
    output logic        inst_resp,
    output cache_line_t inst_rdata,

    // Data cache
    input  logic        data_read,
    input  logic        data_write,
    input  rv32i_word   data_addr,
    input  cache_line_t data_wdata,
    output logic        data_resp,
    output cache_line_t data_rdata,

    // External burst bus
    output logic        burst_read,
    output logic        burst_write,
    output rv32i_word   burst_addr,
    output burst_beat_t burst_wdata,
    input  logic        burst_resp,
    input  burst_beat_t burst_rdata
);

    // ========================================
    // Internal line port
    // ========================================
    rv32i_word   mem_addr;
    logic        mem_read;
    logic        mem_write;
    cache_line_t mem_wdata;
    logic        mem_resp;
    cache_line_t mem_rdata;

    line_arbiter arbiter (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata)
    );

    line_burst_adaptor adaptor (
        .clk         (clk),
        .reset       (reset),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata),
        .burst_read  (burst_read),
        .burst_write (burst_write),
        .burst_addr  (burst_addr),
        .burst_wdata (burst_wdata),
        .burst_resp  (burst_resp),
        .burst_rdata (burst_rdata)
    );

endmodule : memory_subsystem

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                 // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/burst_memory_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_memory_model
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        burst_read,
    input  logic        burst_write,
    input  rv32i_word   burst_addr,
    input  burst_beat_t burst_wdata,
    input  cache_line_t write_line,
    output logic        burst_resp,
    output burst_beat_t burst_rdata
);

    cache_line_t store [rv32i_word];           // Sparse store holding only written lines
    int errors;

    function automatic cache_line_t fill_line(rv32i_word addr);
        cache_line_t line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]}
                               ^ (w * 32'h0101_0101);
        end
        return line;
    endfunction

    function automatic cache_line_t peek_line(rv32i_word addr);
        rv32i_word a;
        a = addr & ~rv32i_word'(line_bytes - 1);
        return store.exists(a) ? store[a] : fill_line(a);
    endfunction

    task automatic check_hold(input rv32i_word a, input logic is_write);
        if ((is_write ? !burst_write : !burst_read) || (burst_read && burst_write)) begin
            errors++;
            $display("Burst request dropped or changed type before four responses");
        end
        if (burst_addr !== a) begin
            errors++;
            $display("burst_addr changed during a burst, %h became %h", a, burst_addr);
        end
    endtask

    task automatic serve_burst();
        rv32i_word   a;
        logic        is_write;
        cache_line_t line;
        cache_line_t exp;
        a        = burst_addr;
        is_write = burst_write;
        line     = peek_line(a);
        exp      = write_line;
        if (burst_read && burst_write) begin
            errors++;
            $display("burst_read and burst_write are high together");
        end
        if (a[4:0] != 5'd0) begin
            errors++;
            $display("burst_addr %h is not aligned to a line", a);
        end
        for (int k = 0; k < beats_per_line; k++) begin
            repeat ($urandom_range(3, 0)) begin
                @(posedge clk);
                #1;
                check_hold(a, is_write);
            end
            burst_resp  = 1'b1;
            burst_rdata = line[beat_width*k +: beat_width];
            if (is_write) begin
                if (burst_wdata !== exp[beat_width*k +: beat_width]) begin
                    errors++;
                    $display("ERR burst_wdata beat %0d got=%h exp=%h", k, burst_wdata,
                             exp[beat_width*k +: beat_width]);
                end
                line[beat_width*k +: beat_width] = burst_wdata;
            end
            @(posedge clk);
            #1;
            burst_resp = 1'b0;
            if (k < beats_per_line - 1) begin
                check_hold(a, is_write);
            end
        end
        if (is_write) begin
            store[a] = line;
        end
        if (burst_read || burst_write) begin
            errors++;
            $display("Burst request still high after the fourth response");
        end
    endtask

    initial begin
        errors      = 0;
        burst_resp  = 1'b0;
        burst_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && (burst_read || burst_write)) begin
                serve_burst();
            end
        end
    end

endmodule : burst_memory_model

`default_nettype wire

// ==== testbench/tb_memory_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_memory_subsystem
    import rv32i_types::*;
;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        inst_read;
    rv32i_word   inst_addr;
    logic        inst_resp;
    cache_line_t inst_rdata;
    logic        data_read;
    logic        data_write;
    rv32i_word   data_addr;
    cache_line_t data_wdata;
    logic        data_resp;
    cache_line_t data_rdata;
    logic        burst_read;
    logic        burst_write;
    rv32i_word   burst_addr;
    burst_beat_t burst_wdata;
    logic        burst_resp;
    burst_beat_t burst_rdata;
    cache_line_t write_line;

    cache_line_t line_model [16];
    logic        dirty [16];                   // Lines hit by an interrupted write
    bit          resp_log [$];                 // One entry per response, 1 for data
    int          errors;
    int          timeouts;
    int          flush_count;
    int          busy;
    logic        quiesce;
    int          waited;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    memory_subsystem dut (.*);

    burst_memory_model mem (
        .clk(clk), .reset(reset), .burst_read(burst_read), .burst_write(burst_write),
        .burst_addr(burst_addr), .burst_wdata(burst_wdata), .write_line(write_line),
        .burst_resp(burst_resp), .burst_rdata(burst_rdata)
    );

    function automatic cache_line_t random_line();
        cache_line_t line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = $urandom;
        end
        return line;
    endfunction

    function automatic rv32i_word random_addr();
        return 32'h0000_4000 + ($urandom_range(15, 0) << 5) + $urandom_range(31, 0);
    endfunction

    task automatic wait_clear_quiesce();
        int n;
        n = 0;
        #1;
        while (quiesce && n < 400) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (quiesce) begin
            timeouts++;
            $display("Timeout: recovery after a flush did not finish");
        end
    endtask

    // Status is 0 when answered, 1 when cut off by a flush, 2 on timeout
    task automatic line_op(input logic dside, input logic wr, input rv32i_word addr,
                           input cache_line_t wdata, output int status);
        int          fc0;
        int          n;
        int          idx;
        logic        resp;
        cache_line_t got;
        wait_clear_quiesce();
        fc0 = flush_count;
        idx = addr[8:5];
        if (dside) begin
            data_addr  = addr;
            data_wdata = wdata;
            data_read  = !wr;
            data_write = wr;
            if (wr) write_line = wdata;
        end else begin
            inst_addr = addr;
            inst_read = 1'b1;
        end
        status = -1;
        n = 0;
        while (status < 0 && n < 200) begin
            @(negedge clk);
            n++;
            resp = dside ? data_resp : inst_resp;
            got  = dside ? data_rdata : inst_rdata;
            if (resp) begin
                status = 0;
                resp_log.push_back(dside);
                if (wr) begin
                    line_model[idx] = wdata;
                end else if (got !== line_model[idx]) begin
                    errors++;
                    $display("ERR %s addr=%h got=%h exp=%h",
                             dside ? "data_rdata" : "inst_rdata", addr, got, line_model[idx]);
                end
            end else if (flush_count != fc0) begin
                status = 1;
                if (wr) dirty[idx] = 1'b1;
            end
        end
        @(posedge clk);                        // Return on the edge that ends the response cycle
        if (status < 0) begin
            timeouts++;
            status = 2;
            $display("Timeout: no response within 200 cycles for address %h", addr);
        end
    endtask

    task automatic drop_request(input logic dside);
        #1;
        if (dside) begin
            data_read  = 1'b0;
            data_write = 1'b0;
        end else begin
            inst_read = 1'b0;
        end
        @(posedge clk);
    endtask

    task automatic do_op(input logic dside, input logic wr, input rv32i_word addr,
                         input cache_line_t wdata);
        int status;
        int tries;
        tries = 0;
        status = 1;
        while (status == 1 && tries < 6) begin
            line_op(dside, wr, addr, wdata, status);
            if (status == 1) drop_request(dside); // Reissue after the flush settles
            tries++;
        end
    endtask

    task automatic random_traffic(input logic dside, input int n);
        logic wr;
        repeat (n) begin
            repeat ($urandom_range(4, 0)) @(posedge clk);
            wr = dside && ($urandom_range(1, 0) == 1);
            do_op(dside, wr, random_addr(), random_line());
            drop_request(dside);
        end
        busy--;
    endtask

    // Flush, then hold requests off until the adaptor has drained its burst
    task automatic flush_cycle();
        int quiet;
        int n;
        quiesce = 1'b1;
        #1;
        flush = 1'b1;
        flush_count++;
        @(posedge clk);
        #1;
        flush = 1'b0;
        quiet = 0;
        n = 0;
        while (quiet < 4 && n < 200) begin
            @(negedge clk);
            n++;
            quiet = (burst_read || burst_write || n < 3) ? 0 : quiet + 1;
        end
        @(posedge clk);
        if (quiet < 4) begin
            timeouts++;
            $display("Timeout: burst bus did not go idle after a flush");
        end
        for (int i = 0; i < 16; i++) begin
            if (dirty[i]) line_model[i] = mem.peek_line(32'h0000_4000 + (i << 5));
            dirty[i] = 1'b0;
        end
        quiesce = 1'b0;
    endtask

    task automatic finish_run();
        $display("Errors: %0d data, %0d burst protocol, %0d timeouts",
                 errors, mem.errors, timeouts);
        if (errors + mem.errors + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // A response with no request behind it means a flushed transfer leaked through
    always @(negedge clk) begin
        if (!reset && inst_resp && !inst_read) begin
            errors++;
            $display("inst_resp went high with no instruction request");
        end
        if (!reset && data_resp && !(data_read || data_write)) begin
            errors++;
            $display("data_resp went high with no data request");
        end
    end

    initial begin
        rv32i_word a;
        cache_line_t wl;
        void'($urandom(32'h6b93f659));
        flush       = 1'b0;
        inst_read   = 1'b0;
        inst_addr   = '0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        write_line  = '0;
        errors      = 0;
        timeouts    = 0;
        flush_count = 0;
        quiesce     = 1'b0;
        for (int i = 0; i < 16; i++) begin
            line_model[i] = mem.peek_line(32'h0000_4000 + (i << 5));
            dirty[i] = 1'b0;
        end
        waited = 0;
        while (reset && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        @(posedge clk);

        // ========================================
        // Write, then read back from both sides
        // ========================================
        a  = random_addr();
        wl = random_line();
        do_op(1'b1, 1'b1, a, wl);
        drop_request(1'b1);
        do_op(1'b1, 1'b0, a, '0);
        drop_request(1'b1);
        do_op(1'b0, 1'b0, a, '0);
        drop_request(1'b0);

        // ========================================
        // Priority and alternation
        // ========================================
        resp_log.delete();
        fork
            begin
                do_op(1'b0, 1'b0, random_addr(), '0);
                drop_request(1'b0);
            end
            begin
                do_op(1'b1, 1'b0, random_addr(), '0);
                drop_request(1'b1);
            end
        join
        if (resp_log.size() != 2 || resp_log[0] != 1'b1) begin
            errors++;
            $display("Data cache was not served first from idle");
        end
        resp_log.delete();
        fork
            begin
                repeat (3) do_op(1'b1, 1'b0, random_addr(), '0);
                drop_request(1'b1);
            end
            begin
                repeat (3) do_op(1'b0, 1'b0, random_addr(), '0);
                drop_request(1'b0);
            end
        join
        for (int k = 0; k < resp_log.size(); k++) begin
            if (resp_log[k] != (k % 2 == 0)) begin
                errors++;
                $display("Responses did not alternate at position %0d", k);
            end
        end

        // ========================================
        // Random traffic with flushes
        // ========================================
        busy = 2;
        fork
            random_traffic(1'b0, 40);
            random_traffic(1'b1, 40);
            while (busy > 0) begin
                waited = $urandom_range(80, 30);
                while (waited > 0 && busy > 0) begin
                    @(posedge clk);
                    waited--;
                end
                if (busy > 0) flush_cycle();
            end
        join
        finish_run();
    end

endmodule : tb_memory_subsystem

`default_nettype wire

// ==== filelist.f ====
verilog/rv32i_types.sv
verilog/line_arbiter.sv
verilog/line_burst_adaptor.sv
verilog/memory_subsystem.sv
testbench/tb_clock_gen.sv
testbench/burst_memory_model.sv
testbench/tb_memory_subsystem.sv
